/* common/qsort_pkg.sv */
/*
  Banked packet sorter shared definitions.
  Sizes of the data path and RAM banks, bank status encoding,
  scoreboard update, RAM request and output beat structs.
*/
`default_nettype none

package qsort_pkg;

  // Data path and bank geometry
  localparam int WORD_W     = 16;
  localparam int BANK_DEPTH = 16;
  localparam int BANK_N     = 4;
  localparam int ADDR_W     = $clog2(BANK_DEPTH);
  localparam int IDX_W      = $clog2(BANK_N);

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [WORD_W-1:0] word_t;
  typedef logic [IDX_W-1:0]  bank_idx_t;

  // Life cycle of a bank, in hand-off order
  typedef enum logic [2:0] {
    IDLE,
    LOADING,
    READY,
    SORTING,
    SORTED,
    UNLOADING
  } bank_status_t;

  // Scoreboard entry, last is length minus one
  typedef struct packed {
    bank_status_t status;
    addr_t        last;
  } bank_state_t;

  // One agent's write into the scoreboard
  typedef struct packed {
    logic        en;
    bank_idx_t   idx;
    bank_state_t state;
  } bank_update_t;

  // One agent's RAM access
  typedef struct packed {
    logic      en;
    logic      wen;
    bank_idx_t idx;
    addr_t     addr;
    word_t     din;
  } sram_req_t;

  // Output beat
  typedef struct packed {
    logic  vld;
    logic  sop;
    logic  eop;
    word_t dat;
  } sorted_beat_t;

endpackage

`default_nettype wire

/* source/spsram.sv */
/*
  Single-port RAM, one bank deep enough for a full packet.
  Write on en with wen, registered read on en without wen.
*/
`timescale 1ns/1ps
`default_nettype none

module spsram (
  input  logic             clk,
  input  logic             en,
  input  logic             wen,
  input  qsort_pkg::addr_t addr,
  input  qsort_pkg::word_t din,
  output qsort_pkg::word_t dout
);

  qsort_pkg::word_t mem [qsort_pkg::BANK_DEPTH];

  always_ff @(posedge clk) begin
    if (en) begin
      if (wen)
        mem[addr] <= din;
      else
        dout <= mem[addr];
    end
  end

endmodule

`default_nettype wire

/* source/bank_memory.sv */
/*
  Bank memory.
  Four single-port RAM banks. Each bank is driven by whichever agent
  request names it; sort and dequeue read data come back one cycle
  later from the bank recorded with the request.
*/
`timescale 1ns/1ps
`default_nettype none

module bank_memory (
  input  logic                 clk,
  input  qsort_pkg::sram_req_t enq_req,
  input  qsort_pkg::sram_req_t sort_req,
  input  qsort_pkg::sram_req_t deq_req,
  output qsort_pkg::word_t     sort_rdata,
  output qsort_pkg::word_t     deq_rdata
);

  qsort_pkg::sram_req_t [qsort_pkg::BANK_N-1:0] bank_req;
  qsort_pkg::word_t     [qsort_pkg::BANK_N-1:0] bank_dout;
  qsort_pkg::bank_idx_t                         sort_idx_q;
  qsort_pkg::bank_idx_t                         deq_idx_q;

  // Request steering, at most one agent per bank by ownership
  always_comb begin
    for (int i = 0; i < qsort_pkg::BANK_N; i++) begin
      bank_req[i] = '0;
      if (enq_req.en && enq_req.idx == qsort_pkg::bank_idx_t'(i))
        bank_req[i] = enq_req;
      else if (sort_req.en && sort_req.idx == qsort_pkg::bank_idx_t'(i))
        bank_req[i] = sort_req;
      else if (deq_req.en && deq_req.idx == qsort_pkg::bank_idx_t'(i))
        bank_req[i] = deq_req;
    end
  end

  for (genvar g = 0; g < qsort_pkg::BANK_N; g++) begin : g_bank
    spsram u_ram (
      .clk  (clk),
      .en   (bank_req[g].en),
      .wen  (bank_req[g].wen),
      .addr (bank_req[g].addr),
      .din  (bank_req[g].din),
      .dout (bank_dout[g])
    );
  end

  // Bank of the read in flight, aligned with registered dout
  always_ff @(posedge clk) begin
    sort_idx_q <= sort_req.idx;
    deq_idx_q  <= deq_req.idx;
  end

  assign sort_rdata = bank_dout[sort_idx_q];
  assign deq_rdata  = bank_dout[deq_idx_q];

endmodule

`default_nettype wire

/* source/bank_scoreboard.sv */
/*
  Bank scoreboard.
  One status/length register per bank. Each agent writes only the bank
  it currently owns, so updates are steered by bank index and never
  collide. Busy is registered from the next-state statuses.
*/
`timescale 1ns/1ps
`default_nettype none

module bank_scoreboard (
  input  logic                                           clk,
  input  logic                                           rst,
  input  qsort_pkg::bank_update_t                        enq_upd,
  input  qsort_pkg::bank_update_t                        sort_upd,
  input  qsort_pkg::bank_update_t                        deq_upd,
  output qsort_pkg::bank_state_t [qsort_pkg::BANK_N-1:0] bank_state,
  output logic                                           busy
);

  qsort_pkg::bank_state_t [qsort_pkg::BANK_N-1:0] state_nxt;
  logic                                           any_busy;

  // Does this update target bank i
  function automatic logic hits(qsort_pkg::bank_update_t upd, int i);
    return upd.en && (upd.idx == qsort_pkg::bank_idx_t'(i));
  endfunction

  always_comb begin
    any_busy = 1'b0;
    for (int i = 0; i < qsort_pkg::BANK_N; i++) begin
      // Hold unless the owning agent writes
      state_nxt[i] = bank_state[i];
      if (hits(enq_upd, i))
        state_nxt[i] = enq_upd.state;
      if (hits(sort_upd, i))
        state_nxt[i] = sort_upd.state;
      if (hits(deq_upd, i))
        state_nxt[i] = deq_upd.state;
      // Any non-idle bank keeps the sorter busy
      if (state_nxt[i].status != qsort_pkg::IDLE)
        any_busy = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < qsort_pkg::BANK_N; i++)
        bank_state[i] <= '{status: qsort_pkg::IDLE, last: '0};
      busy <= 1'b0;
    end else begin
      bank_state <= state_nxt;
      busy       <= any_busy;
    end
  end

endmodule

`default_nettype wire

/* enqueue/enqueue_ctrl.sv */
/*
  Enqueue agent.
  Writes each accepted input word into the bank at its pointer, marks
  the bank LOADING on the first word and READY with its length on eop,
  then moves on to the next bank round-robin.
*/
`timescale 1ns/1ps
`default_nettype none

module enqueue_ctrl (
  input  logic                                           clk,
  input  logic                                           rst,
  input  logic                                           unsorted_vld,
  input  logic                                           unsorted_eop,
  input  qsort_pkg::word_t                               unsorted_dat,
  input  qsort_pkg::bank_state_t [qsort_pkg::BANK_N-1:0] bank_state,
  output logic                                           unsorted_rdy,
  output qsort_pkg::bank_update_t                        upd,
  output qsort_pkg::sram_req_t                           req
);

  typedef enum logic {FSM_IDLE, FSM_LOAD} enq_fsm_t;

  enq_fsm_t               fsm_r;
  qsort_pkg::addr_t       waddr_r;
  qsort_pkg::bank_idx_t   ptr_r;
  qsort_pkg::bank_state_t cur;
  logic                   accept;

  always_comb begin
    cur = bank_state[ptr_r];
    // Open for input while our bank is free or being filled
    unsorted_rdy = (cur.status == qsort_pkg::IDLE) || (cur.status == qsort_pkg::LOADING);
    accept       = unsorted_vld && unsorted_rdy;

    // Word goes straight into RAM
    req.en   = accept;
    req.wen  = 1'b1;
    req.idx  = ptr_r;
    req.addr = waddr_r;
    req.din  = unsorted_dat;

    // Status on first word and on eop
    upd.en           = accept && ((fsm_r == FSM_IDLE) || unsorted_eop);
    upd.idx          = ptr_r;
    upd.state.status = unsorted_eop ? qsort_pkg::READY : qsort_pkg::LOADING;
    upd.state.last   = waddr_r;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      fsm_r   <= FSM_IDLE;
      waddr_r <= '0;
      ptr_r   <= '0;
    end else if (accept) begin
      if (unsorted_eop) begin
        // Packet complete, next packet goes to next bank
        fsm_r   <= FSM_IDLE;
        waddr_r <= '0;
        ptr_r   <= ptr_r + 1'b1;
      end else begin
        fsm_r   <= FSM_LOAD;
        waddr_r <= waddr_r + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* sort/sort_engine.sv */
/*
  Sort agent.
  Exchange sort of one bank in place through its single RAM port.
  Each pass walks j over 0..last-1, reading A[j] and A[j+1] and
  writing them back swapped when out of order. A pass with no swap
  ends the sort and the bank is handed to dequeue as SORTED.
*/
`timescale 1ns/1ps
`default_nettype none

module sort_engine (
  input  logic                                           clk,
  input  logic                                           rst,
  input  qsort_pkg::bank_state_t [qsort_pkg::BANK_N-1:0] bank_state,
  input  qsort_pkg::word_t                               rdata,
  output qsort_pkg::bank_update_t                        upd,
  output qsort_pkg::sram_req_t                           req
);

  typedef enum logic [2:0] {
    WAIT, READ_A, READ_B, COMPARE, WRITE_A, WRITE_B, PASS_END
  } sort_fsm_t;

  sort_fsm_t              fsm_r;
  sort_fsm_t              fsm_nxt;
  qsort_pkg::addr_t       j_r;
  qsort_pkg::word_t       a_r;
  qsort_pkg::word_t       b_r;
  logic                   swapped_r;
  qsort_pkg::bank_idx_t   ptr_r;
  qsort_pkg::bank_state_t cur;
  qsort_pkg::addr_t       j_inc;
  logic                   pass_done;
  logic                   out_of_order;

  always_comb begin
    cur          = bank_state[ptr_r];
    j_inc        = j_r + 1'b1;
    // j+1 reached the last word
    pass_done    = (j_inc == cur.last);
    // rdata holds A[j+1] in COMPARE
    out_of_order = (a_r > rdata);

    req      = '0;
    req.idx  = ptr_r;
    req.addr = j_r;

    upd       = '0;
    upd.idx   = ptr_r;
    upd.state = cur;

    fsm_nxt = fsm_r;
    case (fsm_r)
      WAIT: begin
        if (cur.status == qsort_pkg::READY) begin
          upd.en = 1'b1;
          // Single word is trivially sorted
          if (cur.last == '0) begin
            upd.state.status = qsort_pkg::SORTED;
          end else begin
            upd.state.status = qsort_pkg::SORTING;
            fsm_nxt          = READ_A;
          end
        end
      end
      READ_A: begin
        req.en  = 1'b1;
        fsm_nxt = READ_B;
      end
      READ_B: begin
        req.en   = 1'b1;
        req.addr = j_inc;
        fsm_nxt  = COMPARE;
      end
      COMPARE: begin
        if (out_of_order)
          fsm_nxt = WRITE_A;
        else
          fsm_nxt = pass_done ? PASS_END : READ_A;
      end
      WRITE_A: begin
        // Smaller word down to j
        req.en  = 1'b1;
        req.wen = 1'b1;
        req.din = b_r;
        fsm_nxt = WRITE_B;
      end
      WRITE_B: begin
        req.en   = 1'b1;
        req.wen  = 1'b1;
        req.addr = j_inc;
        req.din  = a_r;
        fsm_nxt  = pass_done ? PASS_END : READ_A;
      end
      PASS_END: begin
        if (swapped_r) begin
          fsm_nxt = READ_A;
        end else begin
          upd.en           = 1'b1;
          upd.state.status = qsort_pkg::SORTED;
          fsm_nxt          = WAIT;
        end
      end
      default: fsm_nxt = WAIT;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      fsm_r     <= WAIT;
      j_r       <= '0;
      swapped_r <= 1'b0;
      ptr_r     <= '0;
    end else begin
      fsm_r <= fsm_nxt;
      // Bank done, move to next one
      if (upd.en && upd.state.status == qsort_pkg::SORTED)
        ptr_r <= ptr_r + 1'b1;
      if (fsm_r == WAIT || fsm_r == PASS_END) begin
        j_r       <= '0;
        swapped_r <= 1'b0;
      end else if (fsm_r == COMPARE && !out_of_order) begin
        j_r <= j_inc;
      end else if (fsm_r == WRITE_B) begin
        j_r       <= j_inc;
        swapped_r <= 1'b1;
      end
    end
  end

  // Held words, A[j] arrives in READ_B and A[j+1] in COMPARE
  always_ff @(posedge clk) begin
    if (fsm_r == READ_B)
      a_r <= rdata;
    if (fsm_r == COMPARE)
      b_r <= rdata;
  end

endmodule

`default_nettype wire

/* dequeue/dequeue_ctrl.sv */
/*
  Dequeue agent.
  Reads a SORTED bank out one word per cycle from address 0 to last,
  frees the bank on the last read and advances round-robin. Beat
  markers follow the RAM read by one stage into the output register.
*/
`timescale 1ns/1ps
`default_nettype none

module dequeue_ctrl (
  input  logic                                           clk,
  input  logic                                           rst,
  input  qsort_pkg::bank_state_t [qsort_pkg::BANK_N-1:0] bank_state,
  input  qsort_pkg::word_t                               rdata,
  output qsort_pkg::bank_update_t                        upd,
  output qsort_pkg::sram_req_t                           req,
  output qsort_pkg::sorted_beat_t                        sorted
);

  typedef enum logic {FSM_IDLE, FSM_EMIT} deq_fsm_t;

  // Beat markers travelling alongside the RAM read
  typedef struct packed {
    logic vld;
    logic sop;
    logic eop;
  } beat_ctl_t;

  deq_fsm_t               fsm_r;
  qsort_pkg::addr_t       raddr_r;
  qsort_pkg::bank_idx_t   ptr_r;
  qsort_pkg::bank_state_t cur;
  logic                   issue;
  logic                   last_rd;
  beat_ctl_t              ctl_d;
  beat_ctl_t              ctl_r;

  always_comb begin
    cur     = bank_state[ptr_r];
    // Start on a sorted bank, then read every cycle
    issue   = (fsm_r == FSM_EMIT) || (cur.status == qsort_pkg::SORTED);
    last_rd = issue && (raddr_r == cur.last);

    req.en   = issue;
    req.wen  = 1'b0;
    req.idx  = ptr_r;
    req.addr = raddr_r;
    req.din  = '0;

    // UNLOADING on first read, IDLE on last
    upd.en           = issue && ((fsm_r == FSM_IDLE) || last_rd);
    upd.idx          = ptr_r;
    upd.state        = cur;
    upd.state.status = last_rd ? qsort_pkg::IDLE : qsort_pkg::UNLOADING;

    ctl_d.vld = issue;
    ctl_d.sop = issue && (fsm_r == FSM_IDLE);
    ctl_d.eop = last_rd;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      fsm_r   <= FSM_IDLE;
      raddr_r <= '0;
      ptr_r   <= '0;
    end else if (issue) begin
      fsm_r   <= last_rd ? FSM_IDLE : FSM_EMIT;
      raddr_r <= last_rd ? '0 : raddr_r + 1'b1;
      if (last_rd)
        ptr_r <= ptr_r + 1'b1;
    end
  end

  // One stage for the RAM, one for the output register
  always_ff @(posedge clk) begin
    if (rst) begin
      ctl_r.vld  <= 1'b0;
      sorted.vld <= 1'b0;
    end else begin
      ctl_r  <= ctl_d;
      sorted <= '{vld: ctl_r.vld, sop: ctl_r.sop, eop: ctl_r.eop, dat: rdata};
    end
  end

endmodule

`default_nettype wire

/* source/bank_sorter.sv */
/*
  Banked packet sorter top level.
  Packets are loaded into one of four RAM banks, sorted in place and
  sent out in arrival order. Enqueue, sort and dequeue run on different
  banks at once, coordinated through the bank scoreboard.
*/
`timescale 1ns/1ps
`default_nettype none

module bank_sorter (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    unsorted_vld,
  input  logic                    unsorted_eop,
  input  qsort_pkg::word_t        unsorted_dat,
  output logic                    unsorted_rdy,
  output qsort_pkg::sorted_beat_t sorted,
  output logic                    busy
);

  // Scoreboard view shared by all agents
  qsort_pkg::bank_state_t [qsort_pkg::BANK_N-1:0] bank_state;

  // Per-agent scoreboard writes
  qsort_pkg::bank_update_t enq_upd;
  qsort_pkg::bank_update_t sort_upd;
  qsort_pkg::bank_update_t deq_upd;

  // Per-agent RAM accesses and read return
  qsort_pkg::sram_req_t enq_req;
  qsort_pkg::sram_req_t sort_req;
  qsort_pkg::sram_req_t deq_req;
  qsort_pkg::word_t     sort_rdata;
  qsort_pkg::word_t     deq_rdata;

  enqueue_ctrl u_enqueue (
    .clk          (clk),
    .rst          (rst),
    .unsorted_vld (unsorted_vld),
    .unsorted_eop (unsorted_eop),
    .unsorted_dat (unsorted_dat),
    .bank_state   (bank_state),
    .unsorted_rdy (unsorted_rdy),
    .upd          (enq_upd),
    .req          (enq_req)
  );

  sort_engine u_sort (
    .clk        (clk),
    .rst        (rst),
    .bank_state (bank_state),
    .rdata      (sort_rdata),
    .upd        (sort_upd),
    .req        (sort_req)
  );

  dequeue_ctrl u_dequeue (
    .clk        (clk),
    .rst        (rst),
    .bank_state (bank_state),
    .rdata      (deq_rdata),
    .upd        (deq_upd),
    .req        (deq_req),
    .sorted     (sorted)
  );

  bank_scoreboard u_scoreboard (
    .clk        (clk),
    .rst        (rst),
    .enq_upd    (enq_upd),
    .sort_upd   (sort_upd),
    .deq_upd    (deq_upd),
    .bank_state (bank_state),
    .busy       (busy)
  );

  bank_memory u_memory (
    .clk        (clk),
    .enq_req    (enq_req),
    .sort_req   (sort_req),
    .deq_req    (deq_req),
    .sort_rdata (sort_rdata),
    .deq_rdata  (deq_rdata)
  );

endmodule

`default_nettype wire

/* verif/tb_bank_sorter.sv */
/*
  Testbench for the banked packet sorter.
  Sends packets of assorted lengths and orders, keeps a reference queue
  of the sorted words and checks every output beat with assertions.
  A watchdog bounds the run from the packet count.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_bank_sorter;

  localparam int CLK_PERIOD  = 10;
  localparam int RST_CYCLES  = 16;
  localparam int DEPTH       = qsort_pkg::BANK_DEPTH;
  localparam int NUM_PKTS    = 15;
  // Worst case exchange sort of one bank plus unload
  localparam int PKT_CYCLES  = 4 * DEPTH * DEPTH + 4 * DEPTH;
  localparam int MARGIN      = 4000;
  localparam int WATCHDOG_NS = CLK_PERIOD * (RST_CYCLES + NUM_PKTS * PKT_CYCLES + MARGIN);

  // Packet content kinds
  localparam int KIND_RANDOM = 0;
  localparam int KIND_DUPS   = 1;
  localparam int KIND_UP     = 2;
  localparam int KIND_DOWN   = 3;

  logic                    clk;
  logic                    rst;
  logic                    unsorted_vld;
  logic                    unsorted_eop;
  qsort_pkg::word_t        unsorted_dat;
  logic                    unsorted_rdy;
  qsort_pkg::sorted_beat_t sorted;
  logic                    busy;

  integer seed = 32'h99932837;

  // Reference model written by the stimulus and read by the monitor
  qsort_pkg::word_t exp_dat[$];
  logic             exp_sop[$];
  logic             exp_eop[$];
  int               rd_idx;

  qsort_pkg::word_t pkt [DEPTH];
  int               main_errors;
  int               mon_errors;
  int               tests_passed;
  int               tests_failed;
  logic             burst_active;
  logic             rdy_fell;

  bank_sorter dut (
    .clk          (clk),
    .rst          (rst),
    .unsorted_vld (unsorted_vld),
    .unsorted_eop (unsorted_eop),
    .unsorted_dat (unsorted_dat),
    .unsorted_rdy (unsorted_rdy),
    .sorted       (sorted),
    .busy         (busy)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Compare and report one value
  function automatic bit value_ok(string name, qsort_pkg::word_t expv, qsort_pkg::word_t act);
    value_ok = 1'b1;
    assert (act === expv) else begin
      $display("[ERROR] %0t %s expected %h got %h", $time, name, expv, act);
      value_ok = 1'b0;
    end
  endfunction

  // Output monitor sampling registered outputs mid-cycle
  always @(negedge clk) begin
    if (!rst && sorted.vld) begin
      assert (rd_idx < exp_dat.size()) else begin
        $display("%0t: output beat arrived while no packet was expected", $time);
        mon_errors++;
      end
      if (rd_idx < exp_dat.size()) begin
        if (!value_ok("sorted.dat", exp_dat[rd_idx], sorted.dat))
          mon_errors++;
        if (!value_ok("sorted.sop", qsort_pkg::word_t'(exp_sop[rd_idx]),
                      qsort_pkg::word_t'(sorted.sop)))
          mon_errors++;
        if (!value_ok("sorted.eop", qsort_pkg::word_t'(exp_eop[rd_idx]),
                      qsort_pkg::word_t'(sorted.eop)))
          mon_errors++;
        rd_idx++;
      end
    end
    // Back-pressure seen during the burst
    if (burst_active && !unsorted_rdy)
      rdy_fell = 1'b1;
  end

  task automatic fill_packet(int len, int kind);
    for (int i = 0; i < len; i++) begin
      case (kind)
        KIND_DUPS: pkt[i] = qsort_pkg::word_t'($unsigned($random(seed)) % 4);
        KIND_UP:   pkt[i] = qsort_pkg::word_t'(i * 1000 + ($random(seed) & 255));
        KIND_DOWN: pkt[i] = qsort_pkg::word_t'((len - 1 - i) * 1000 + ($random(seed) & 255));
        default:   pkt[i] = qsort_pkg::word_t'($random(seed));
      endcase
    end
  endtask

  // Insertion sort of the packet into the reference queue
  task automatic expect_packet(int len);
    qsort_pkg::word_t tmp [DEPTH];
    qsort_pkg::word_t key;
    int               k;
    for (int i = 0; i < len; i++)
      tmp[i] = pkt[i];
    for (int i = 1; i < len; i++) begin
      key = tmp[i];
      k   = i - 1;
      while (k >= 0 && tmp[k] > key) begin
        tmp[k + 1] = tmp[k];
        k--;
      end
      tmp[k + 1] = key;
    end
    for (int i = 0; i < len; i++) begin
      exp_dat.push_back(tmp[i]);
      exp_sop.push_back(i == 0);
      exp_eop.push_back(i == len - 1);
    end
  endtask

  // Called on a falling edge, returns on the falling edge after the last word
  task automatic send_packet(int len, bit hold_vld);
    expect_packet(len);
    for (int i = 0; i < len; i++) begin
      unsorted_vld = 1'b1;
      unsorted_dat = pkt[i];
      unsorted_eop = (i == len - 1);
      // Ready only changes after a rising edge
      while (!unsorted_rdy)
        @(negedge clk);
      @(negedge clk);
    end
    unsorted_eop = 1'b0;
    if (!hold_vld)
      unsorted_vld = 1'b0;
  endtask

  task automatic wait_drained();
    while (rd_idx != exp_dat.size())
      @(negedge clk);
  endtask

  task automatic finish_test(string name, int err_start);
    if (main_errors + mon_errors == err_start) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed", name);
    end
  endtask

  // Run bound from the packet count
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before all packets came out");
    $display("TB FAILED");
    $finish;
  end

  initial begin
    int err_start;
    int len;
    clk          = 1'b0;
    rst          = 1'b1;
    unsorted_vld = 1'b0;
    unsorted_eop = 1'b0;
    unsorted_dat = '0;
    rd_idx       = 0;
    main_errors  = 0;
    mon_errors   = 0;
    tests_passed = 0;
    tests_failed = 0;
    burst_active = 1'b0;
    rdy_fell     = 1'b0;
    repeat (RST_CYCLES) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    // Idle state after reset
    err_start = main_errors + mon_errors;
    if (!value_ok("sorted.vld", '0, qsort_pkg::word_t'(sorted.vld)))
      main_errors++;
    if (!value_ok("busy", '0, qsort_pkg::word_t'(busy)))
      main_errors++;
    if (!value_ok("unsorted_rdy", 16'd1, qsort_pkg::word_t'(unsorted_rdy)))
      main_errors++;
    finish_test("reset state", err_start);

    err_start = main_errors + mon_errors;
    len = 2 + int'($unsigned($random(seed)) % 15);
    fill_packet(len, KIND_RANDOM);
    send_packet(len, 1'b0);
    // Bank holds the packet until it is unloaded
    if (!value_ok("busy", 16'd1, qsort_pkg::word_t'(busy)))
      main_errors++;
    wait_drained();
    finish_test($sformatf("random packet of %0d words", len), err_start);

    err_start = main_errors + mon_errors;
    fill_packet(1, KIND_RANDOM);
    send_packet(1, 1'b0);
    wait_drained();
    finish_test("one-word packet", err_start);

    err_start = main_errors + mon_errors;
    fill_packet(DEPTH, KIND_DUPS);
    send_packet(DEPTH, 1'b0);
    wait_drained();
    finish_test("duplicate values", err_start);

    err_start = main_errors + mon_errors;
    fill_packet(DEPTH, KIND_UP);
    send_packet(DEPTH, 1'b0);
    wait_drained();
    finish_test("already in order", err_start);

    err_start = main_errors + mon_errors;
    fill_packet(DEPTH, KIND_DOWN);
    send_packet(DEPTH, 1'b0);
    wait_drained();
    finish_test("reverse order", err_start);

    // Ten packets with vld held, long enough to fill every bank
    err_start    = main_errors + mon_errors;
    burst_active = 1'b1;
    for (int p = 0; p < 10; p++) begin
      len = 8 + int'($unsigned($random(seed)) % 9);
      fill_packet(len, KIND_RANDOM);
      send_packet(len, p != 9);
    end
    burst_active = 1'b0;
    wait_drained();
    assert (rdy_fell) else begin
      $display("Input ready never fell during the back-to-back burst");
      main_errors++;
    end
    finish_test("back-to-back burst", err_start);

    // Drained pipeline returns to idle
    err_start = main_errors + mon_errors;
    @(negedge clk);
    if (!value_ok("busy", '0, qsort_pkg::word_t'(busy)))
      main_errors++;
    if (!value_ok("unsorted_rdy", 16'd1, qsort_pkg::word_t'(unsorted_rdy)))
      main_errors++;
    finish_test("drained idle", err_start);

    $display("tests passed %0d, failed %0d, errors %0d",
             tests_passed, tests_failed, main_errors + mon_errors);
    if (tests_failed == 0 && main_errors + mon_errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
common/qsort_pkg.sv
source/spsram.sv
source/bank_memory.sv
source/bank_scoreboard.sv
enqueue/enqueue_ctrl.sv
sort/sort_engine.sv
dequeue/dequeue_ctrl.sv
source/bank_sorter.sv
verif/tb_bank_sorter.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and pass only if the log holds the pass line
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -f vlog.f --top-module tb_bank_sorter \
    -o tb_bank_sorter > build.log 2>&1 &&
  ./obj_dir/tb_bank_sorter > sim.log 2>&1 ;
cat sim.log 2>/dev/null ;
grep -qx "TB PASSED" sim.log 2>/dev/null && echo "simulation ok" ||
  { echo "simulation or build failed, see build.log and sim.log"; exit 1; }
